// File: vlog.f
hw/timerPkg.sv
hw/timerRegs.sv
hw/timerCounter.sv
hw/compareOutput.sv
hw/intFlags.sv
hw/timerTop.sv
dv/timer_properties.sv
dv/timerTb.sv

// File: Makefile
# Verilator flow for the timer testbench

VERILATOR ?= verilator
TOP ?= timerTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert -Wall

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/timerTb.sv
`timescale 1ns/1ps

module timerTb;
	import timerPkg::*;

	localparam int CycleLimit = 4000;

	typedef struct packed {
		logic [15:0] count;
		logic [15:0] ocrA;
		logic [15:0] ocrB;
		logic [7:0] tccrA;
		logic [7:0] tccrB;
		logic [7:0] timsk;
		logic [7:0] temp;
		logic [2:0] flags;
		logic pinA;
		logic pinB;
	} refState_t;

	logic cp2;
	logic ireset;
	busReq_t bus;
	irqAck_t ack;
	logic [7:0] dbusOut;
	logic outEn;
	logic ocA;
	logic ocB;
	logic ocAEn;
	logic ocBEn;
	logic ovfIrq;
	logic cmpAIrq;
	logic cmpBIrq;

	refState_t model;
	logic checkOn;
	logic [31:0] lfsr;
	int cycles;
	int errCount;

	timerTop u_dut (
		.cp2(cp2), .ireset(ireset), .bus(bus), .ack(ack),
		.dbusOut(dbusOut), .outEn(outEn),
		.ocA(ocA), .ocB(ocB), .ocAEn(ocAEn), .ocBEn(ocBEn),
		.ovfIrq(ovfIrq), .cmpAIrq(cmpAIrq), .cmpBIrq(cmpBIrq)
	);

	initial begin
		cp2 = 1'b0;
		forever #50 cp2 = ~cp2;
	end

	task automatic reportFail(input string msg);
		errCount++;
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkEq(input string name, input logic [15:0] got, input logic [15:0] exp);
		assert (got === exp)
		else reportFail($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [15:0] takeBits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic pinNext(input logic p, input logic [1:0] com, input logic m);
		if (com == 2'b00)
			return 1'b0;
		if (!m)
			return p;
		case (com)
			2'b01: return ~p;
			2'b10: return 1'b0;
			default: return 1'b1;
		endcase
	endfunction

	// Next model state from the bus rules of the timer
	function automatic refState_t refStep(input refState_t s, input busReq_t b, input irqAck_t a);
		refState_t n;
		logic load;
		logic tick;
		logic ovf;
		logic mA;
		logic mB;
		logic [2:0] setv;
		logic [2:0] clr;
		n = s;
		load = b.ramwe && (b.ramAddr == addrTcntL);
		tick = (s.tccrB[2:0] != 3'd0) && !load;
		ovf = tick && (s.count == 16'hFFFF);
		mA = tick && (s.count == s.ocrA);
		mB = tick && (s.count == s.ocrB);
		setv = {mB, mA, ovf};
		clr[0] = a.strobe && (a.vec == vecOvf);
		clr[1] = a.strobe && (a.vec == vecCmpA);
		clr[2] = a.strobe && (a.vec == vecCmpB);
		if (b.iowe && (b.ioAddr == addrTifr))
			clr = clr | b.dbusIn[2:0];
		for (int i = 0; i < 3; i++) begin
			if (!s.flags[i])
				n.flags[i] = setv[i];
			else if (clr[i])
				n.flags[i] = 1'b0;
		end
		n.pinA = pinNext(s.pinA, s.tccrA[7:6], mA);
		n.pinB = pinNext(s.pinB, s.tccrA[5:4], mB);
		if (load)
			n.count = {s.temp, b.dbusIn};
		else if (tick)
			n.count = (s.tccrB[3] && s.count == s.ocrA) ? 16'd0 : s.count + 16'd1;
		if (b.ramwe) begin
			case (b.ramAddr)
				addrTccrA: n.tccrA = b.dbusIn & 8'hF0;
				addrTccrB: n.tccrB = b.dbusIn & 8'h0F;
				addrTimsk: n.timsk = b.dbusIn & 8'h07;
				addrOcrAL: n.ocrA = {s.temp, b.dbusIn};
				addrOcrBL: n.ocrB = {s.temp, b.dbusIn};
				addrTcntH, addrOcrAH, addrOcrBH: n.temp = b.dbusIn;
				default: ;
			endcase
		end
		if (b.ramre && b.ramAddr == addrTcntL)
			n.temp = s.count[15:8];
		return n;
	endfunction

	// Expected {outEn, dbusOut}
	function automatic logic [8:0] refRead(input refState_t s, input busReq_t b);
		if (b.iore)
			return (b.ioAddr == addrTifr) ? {1'b1, 5'b0, s.flags} : 9'h0;
		if (!b.ramre)
			return 9'h0;
		case (b.ramAddr)
			addrTccrA: return {1'b1, s.tccrA};
			addrTccrB: return {1'b1, s.tccrB};
			addrTcntL: return {1'b1, s.count[7:0]};
			addrTcntH: return {1'b1, s.temp};
			addrOcrAL: return {1'b1, s.ocrA[7:0]};
			addrOcrAH: return {1'b1, s.ocrA[15:8]};
			addrOcrBL: return {1'b1, s.ocrB[7:0]};
			addrOcrBH: return {1'b1, s.ocrB[15:8]};
			addrTimsk: return {1'b1, s.timsk};
			default: return 9'h0;
		endcase
	endfunction

	always @(posedge cp2 or negedge ireset) begin
		if (!ireset)
			model <= '0;
		else
			model <= refStep(model, bus, ack);
	end

	// Compare every output at mid-cycle
	always @(negedge cp2) begin
		logic [8:0] rd;
		if (checkOn) begin
			rd = refRead(model, bus);
			checkEq("dbusOut", dbusOut, rd[7:0]);
			checkEq("outEn", outEn, rd[8]);
			checkEq("ocA", ocA, model.pinA);
			checkEq("ocB", ocB, model.pinB);
			checkEq("ocAEn", ocAEn, model.tccrA[7:6] != 2'b00);
			checkEq("ocBEn", ocBEn, model.tccrA[5:4] != 2'b00);
			checkEq("ovfIrq", ovfIrq, model.flags[0] & model.timsk[0]);
			checkEq("cmpAIrq", cmpAIrq, model.flags[1] & model.timsk[1]);
			checkEq("cmpBIrq", cmpBIrq, model.flags[2] & model.timsk[2]);
		end
	end

	always @(posedge cp2) begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit) begin
			$display("Timeout: tests did not finish within %0d cycles", CycleLimit);
			$display("STATUS: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic writeHold(input logic [11:0] addr, input logic [7:0] data, input int n);
		busReq_t r;
		r = '0;
		r.ramAddr = addr;
		r.ramwe = 1'b1;
		r.dbusIn = data;
		@(posedge cp2);
		bus <= r;
		repeat (n) @(posedge cp2);
		bus <= '0;
	endtask

	task automatic writeRam(input logic [11:0] addr, input logic [7:0] data);
		writeHold(addr, data, 1);
	endtask

	task automatic write16(input logic [11:0] lowAddr, input logic [15:0] val);
		writeRam(lowAddr + 12'd1, val[15:8]); // High byte first
		writeRam(lowAddr, val[7:0]);
	endtask

	task automatic readRam(input logic [11:0] addr, output logic [7:0] data);
		busReq_t r;
		r = '0;
		r.ramAddr = addr;
		r.ramre = 1'b1;
		@(posedge cp2);
		bus <= r;
		@(negedge cp2);
		data = dbusOut;
		@(posedge cp2);
		bus <= '0;
	endtask

	task automatic read16(input logic [11:0] lowAddr, output logic [15:0] val);
		logic [7:0] lo;
		logic [7:0] hi;
		readRam(lowAddr, lo); // Low byte first
		readRam(lowAddr + 12'd1, hi);
		val = {hi, lo};
	endtask

	task automatic accessIo(input logic wr, input logic [7:0] wdata, output logic [7:0] rdata);
		busReq_t r;
		r = '0;
		r.ioAddr = addrTifr;
		r.iowe = wr;
		r.iore = !wr;
		r.dbusIn = wdata;
		@(posedge cp2);
		bus <= r;
		@(negedge cp2);
		rdata = dbusOut;
		@(posedge cp2);
		bus <= '0;
	endtask

	task automatic pulseAck(input logic [5:0] vec);
		@(posedge cp2);
		ack <= '{vec: vec, strobe: 1'b1};
		@(posedge cp2);
		ack <= '0;
	endtask

	task automatic waitLevel(input int which, input logic level, input string what);
		logic cur;
		for (int i = 0; i < 40; i++) begin
			@(negedge cp2);
			cur = (which == 0) ? ocA : (which == 1) ? ocB : (which == 2) ? ovfIrq : cmpBIrq;
			if (cur === level)
				return;
		end
		reportFail($sformatf("%s did not reach %0d in 40 cycles", what, level));
	endtask

	initial begin
		logic [7:0] b8;
		logic [15:0] v16;
		logic [15:0] exp16;
		logic pinBefore;
		int period;
		lfsr = 32'h6fc1434a;
		cycles = 0;
		errCount = 0;
		checkOn = 1'b0;
		bus = '0;
		ack = '0;
		ireset = 1'b0;
		repeat (8) @(posedge cp2);
		ireset <= 1'b1;
		checkOn = 1'b1;

		// Reset values of TCCRnA/B, TCNT, OCRnA, OCRnB and TIMSK
		for (int i = 0; i < 9; i++) begin
			readRam(i == 8 ? addrTimsk :
				addrTccrA + 12'(i < 2 ? i : (i < 4 ? i + 2 : i + 4)), b8);
			checkEq("reset register", b8, 8'h00);
		end
		accessIo(1'b0, 8'h00, b8);
		checkEq("reset TIFR", b8, 8'h00);

		// Random readback with OCR atomic and control bits masked
		for (int k = 0; k < 4; k++) begin
			exp16 = takeBits(16);
			write16(addrOcrAL, exp16);
			read16(addrOcrAL, v16);
			checkEq("OCRnA", v16, exp16);
			exp16 = takeBits(16);
			write16(addrOcrBL, exp16);
			read16(addrOcrBL, v16);
			checkEq("OCRnB", v16, exp16);
			b8 = 8'(takeBits(8));
			writeRam(addrTccrA, b8);
			readRam(addrTccrA, v16[7:0]);
			checkEq("TCCRnA", v16[7:0], b8 & 8'hF0);
			b8 = 8'(takeBits(8));
			writeRam(addrTimsk, b8);
			readRam(addrTimsk, v16[7:0]);
			checkEq("TIMSK", v16[7:0], b8 & 8'h07);
		end
		b8 = 8'(takeBits(8)) | 8'h08;
		writeRam(addrTccrB, b8);
		readRam(addrTccrB, v16[7:0]);
		checkEq("TCCRnB", v16[7:0], b8 & 8'h0F);

		// Normal mode counting and atomic TCNT sample
		writeRam(addrTccrA, 8'h00);
		writeRam(addrTccrB, 8'h01);
		exp16 = takeBits(16);
		write16(addrTcntL, exp16);
		repeat (7) @(posedge cp2);
		read16(addrTcntL, v16);
		checkEq("TCNT", v16, exp16 + 16'd8); // 7 idle edges plus the read edge

		// CTC with toggle on A
		writeRam(addrTccrB, 8'h00);
		write16(addrOcrAL, 16'd5);
		write16(addrTcntL, 16'd0);
		writeRam(addrTccrA, 8'h40);
		writeRam(addrTccrB, 8'h09);
		waitLevel(0, ~ocA, "ocA");
		pinBefore = ocA;
		period = 0;
		while (ocA === pinBefore && period < 40) begin
			@(negedge cp2);
			period++;
		end
		checkEq("ocA period", 16'(period), 16'd6);
		for (int k = 0; k < 5; k++) begin
			read16(addrTcntL, v16);
			assert (v16 <= 16'd5)
			else reportFail($sformatf("TCNT %h went past TOP in CTC mode", v16));
		end

		// Overflow flag and acknowledge
		writeRam(addrTccrB, 8'h00);
		writeRam(addrTccrA, 8'h00);
		writeRam(addrTimsk, 8'h07);
		accessIo(1'b1, 8'h07, b8);
		write16(addrTcntL, 16'hFFFC);
		writeRam(addrTccrB, 8'h01);
		waitLevel(2, 1'b1, "ovfIrq");
		pulseAck(vecOvf);
		@(negedge cp2);
		checkEq("ovfIrq after ack", ovfIrq, 1'b0);

		// Compare B flag cleared by writing a one
		writeRam(addrTccrB, 8'h00);
		write16(addrOcrBL, 16'h0010);
		write16(addrTcntL, 16'h000C);
		accessIo(1'b1, 8'h04, b8);
		writeRam(addrTccrB, 8'h01);
		waitLevel(3, 1'b1, "cmpBIrq");
		writeRam(addrTccrB, 8'h00);
		accessIo(1'b1, 8'h00, b8);
		accessIo(1'b0, 8'h00, b8);
		checkEq("TIFR after zero write", b8[2], 1'b1);
		accessIo(1'b1, 8'h04, b8);
		accessIo(1'b0, 8'h00, b8);
		checkEq("TIFR after one write", b8[2], 1'b0);

		// Set and clear on B followed by a TCNT write that masks the match
		write16(addrOcrBL, 16'h0020);
		write16(addrTcntL, 16'h001C);
		writeRam(addrTccrA, 8'h30);
		writeRam(addrTccrB, 8'h01);
		waitLevel(1, 1'b1, "ocB");
		checkEq("ocBEn", ocBEn, 1'b1);
		writeRam(addrTccrB, 8'h00);
		writeRam(addrTccrA, 8'h20);
		write16(addrTcntL, 16'h001C);
		writeRam(addrTccrB, 8'h01);
		waitLevel(1, 1'b0, "ocB");
		writeRam(addrTccrA, 8'h10);
		writeRam(addrTcntH, 8'h00);
		pinBefore = ocB;
		writeHold(addrTcntL, 8'h20, 2); // Second write cycle sees TCNT equal to OCRnB
		@(negedge cp2);
		checkEq("ocB during TCNT write", ocB, pinBefore);
		waitLevel(1, ~pinBefore, "ocB");

		writeRam(addrTccrB, 8'h00);
		repeat (4) @(posedge cp2);
		if (errCount == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("STATUS: FAIL");
			$fatal(1, "errors seen");
		end
	end

endmodule

// File: dv/timer_properties.sv
`timescale 1ns/1ps

module timerProps (
	input logic cp2,
	input logic ireset,
	input timerPkg::irqAck_t ack,
	input logic [7:0] timsk,
	input logic [7:0] tifr,
	input logic ovfIrq,
	input logic cmpAIrq,
	input logic cmpBIrq
);
	import timerPkg::*;

	// Interrupt lines are flag AND mask
	assert property (@(posedge cp2) disable iff (!ireset)
		ovfIrq == (tifr[flagOvf] & timsk[flagOvf]))
		else $error("ovfIrq differs from its flag and mask");
	assert property (@(posedge cp2) disable iff (!ireset)
		cmpAIrq == (tifr[flagCmpA] & timsk[flagCmpA]))
		else $error("cmpAIrq differs from its flag and mask");
	assert property (@(posedge cp2) disable iff (!ireset)
		cmpBIrq == (tifr[flagCmpB] & timsk[flagCmpB]))
		else $error("cmpBIrq differs from its flag and mask");

	// Acknowledged flag is gone one edge later
	assert property (@(posedge cp2) disable iff (!ireset)
		(ack.strobe && ack.vec == vecOvf && tifr[flagOvf]) |=> !tifr[flagOvf])
		else $error("Overflow flag survived its acknowledge");
	assert property (@(posedge cp2) disable iff (!ireset)
		(ack.strobe && ack.vec == vecCmpA && tifr[flagCmpA]) |=> !tifr[flagCmpA])
		else $error("Compare A flag survived its acknowledge");
	assert property (@(posedge cp2) disable iff (!ireset)
		(ack.strobe && ack.vec == vecCmpB && tifr[flagCmpB]) |=> !tifr[flagCmpB])
		else $error("Compare B flag survived its acknowledge");

endmodule

bind intFlags timerProps uProps (
	.cp2(cp2),
	.ireset(ireset),
	.ack(ack),
	.timsk(timsk),
	.tifr(tifr),
	.ovfIrq(ovfIrq),
	.cmpAIrq(cmpAIrq),
	.cmpBIrq(cmpBIrq)
);

// File: hw/timerTop.sv
`timescale 1ns/1ps

module timerTop (
	input logic cp2,
	input logic ireset,
	input timerPkg::busReq_t bus,
	input timerPkg::irqAck_t ack,
	output logic [7:0] dbusOut,
	output logic outEn,
	output logic ocA,
	output logic ocB,
	output logic ocAEn,
	output logic ocBEn,
	output logic ovfIrq,
	output logic cmpAIrq,
	output logic cmpBIrq
);
	import timerPkg::*;

	timerCfg_t cfg;
	cntLoad_t load;
	cntEvent_t evt;
	logic [15:0] ocrA;
	logic [15:0] ocrB;
	logic [15:0] count;
	logic [7:0] timsk;
	logic [7:0] tifr;

	timerRegs uRegs (
		.cp2(cp2),
		.ireset(ireset),
		.bus(bus),
		.count(count),
		.tifr(tifr),
		.cfg(cfg),
		.ocrA(ocrA),
		.ocrB(ocrB),
		.timsk(timsk),
		.load(load),
		.dbusOut(dbusOut),
		.outEn(outEn)
	);

	timerCounter uCounter (
		.cp2(cp2),
		.ireset(ireset),
		.cfg(cfg),
		.ocrA(ocrA),
		.ocrB(ocrB),
		.load(load),
		.count(count),
		.evt(evt)
	);

	// Same channel logic, one per compare register
	compareOutput uCmpA (
		.cp2(cp2),
		.ireset(ireset),
		.com(cfg.comA),
		.match(evt.matchA),
		.pin(ocA),
		.pinEn(ocAEn)
	);

	compareOutput uCmpB (
		.cp2(cp2),
		.ireset(ireset),
		.com(cfg.comB),
		.match(evt.matchB),
		.pin(ocB),
		.pinEn(ocBEn)
	);

	intFlags uFlags (
		.cp2(cp2),
		.ireset(ireset),
		.bus(bus),
		.ack(ack),
		.evt(evt),
		.timsk(timsk),
		.tifr(tifr),
		.ovfIrq(ovfIrq),
		.cmpAIrq(cmpAIrq),
		.cmpBIrq(cmpBIrq)
	);

endmodule

// File: hw/intFlags.sv
`timescale 1ns/1ps

module intFlags (
	input logic cp2,
	input logic ireset,
	input timerPkg::busReq_t bus,
	input timerPkg::irqAck_t ack,
	input timerPkg::cntEvent_t evt,
	input logic [7:0] timsk,
	output logic [7:0] tifr,
	output logic ovfIrq,
	output logic cmpAIrq,
	output logic cmpBIrq
);
	import timerPkg::*;

	logic [2:0] flags;
	logic [2:0] setReq;
	logic [2:0] ackReq;
	logic [2:0] clrReq;
	logic tifrWr;

	assign setReq[flagOvf] = evt.ovf;
	assign setReq[flagCmpA] = evt.matchA;
	assign setReq[flagCmpB] = evt.matchB;

	// Vector acknowledge from the core
	assign ackReq[flagOvf] = ack.strobe && (ack.vec == vecOvf);
	assign ackReq[flagCmpA] = ack.strobe && (ack.vec == vecCmpA);
	assign ackReq[flagCmpB] = ack.strobe && (ack.vec == vecCmpB);

	// Writing a one clears, a zero leaves the flag alone
	assign tifrWr = bus.iowe && (bus.ioAddr == addrTifr);
	assign clrReq = ackReq | ({3{tifrWr}} & bus.dbusIn[2:0]);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			flags <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (!flags[i])
					flags[i] <= setReq[i];
				else if (clrReq[i])
					flags[i] <= 1'b0; // Pending flag ignores new events
			end
		end
	end

	assign tifr = {5'b0, flags};

	assign ovfIrq = flags[flagOvf] & timsk[flagOvf];
	assign cmpAIrq = flags[flagCmpA] & timsk[flagCmpA];
	assign cmpBIrq = flags[flagCmpB] & timsk[flagCmpB];

endmodule

// File: hw/compareOutput.sv
`timescale 1ns/1ps

module compareOutput (
	input logic cp2,
	input logic ireset,
	input logic [1:0] com,
	input logic match,
	output logic pin,
	output logic pinEn
);
	import timerPkg::*;

	// Pin drives the port only while the channel is in use
	assign pinEn = (com != comOff);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			pin <= 1'b0;
		end else if (com == comOff) begin
			pin <= 1'b0; // Disconnected channel parks low
		end else if (match) begin
			case (com)
				comToggle: pin <= ~pin;
				comClear: pin <= 1'b0;
				comSet: pin <= 1'b1;
				default: pin <= pin;
			endcase
		end
	end

endmodule

// File: hw/timerCounter.sv
`timescale 1ns/1ps

module timerCounter (
	input logic cp2,
	input logic ireset,
	input timerPkg::timerCfg_t cfg,
	input logic [15:0] ocrA,
	input logic [15:0] ocrB,
	input timerPkg::cntLoad_t load,
	output logic [15:0] count,
	output timerPkg::cntEvent_t evt
);
	import timerPkg::*;

	logic [15:0] top;
	logic atTop;

	// CTC wraps at OCRnA, normal mode at the full range
	assign top = (cfg.mode == wgmCtc) ? ocrA : cntMax;
	assign atTop = (count == top);

	// A bus load owns the cycle, so nothing fires then
	assign evt.tick = cfg.run && !load.valid;
	assign evt.ovf = evt.tick && (count == cntMax);
	assign evt.matchA = evt.tick && (count == ocrA);
	assign evt.matchB = evt.tick && (count == ocrB);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			count <= '0;
		end else if (load.valid) begin
			count <= load.value;
		end else if (evt.tick) begin
			if (atTop)
				count <= '0;
			else
				count <= count + 16'd1;
		end
	end

endmodule

// File: hw/timerRegs.sv
`timescale 1ns/1ps

module timerRegs (
	input logic cp2,
	input logic ireset,
	input timerPkg::busReq_t bus,
	input logic [15:0] count,
	input logic [7:0] tifr,
	output timerPkg::timerCfg_t cfg,
	output logic [15:0] ocrA,
	output logic [15:0] ocrB,
	output logic [7:0] timsk,
	output timerPkg::cntLoad_t load,
	output logic [7:0] dbusOut,
	output logic outEn
);
	import timerPkg::*;

	logic [7:0] tccrA;
	logic [7:0] tccrB;
	logic [7:0] temp; // Shared high-byte latch

	logic wrTccrA;
	logic wrTccrB;
	logic wrTimsk;
	logic wrTcntL;
	logic wrOcrAL;
	logic wrOcrBL;
	logic wrHigh;
	logic rdTcntL;

	logic [7:0] ramData;
	logic ramHit;

	assign wrTccrA = bus.ramwe && (bus.ramAddr == addrTccrA);
	assign wrTccrB = bus.ramwe && (bus.ramAddr == addrTccrB);
	assign wrTimsk = bus.ramwe && (bus.ramAddr == addrTimsk);
	assign wrTcntL = bus.ramwe && (bus.ramAddr == addrTcntL);
	assign wrOcrAL = bus.ramwe && (bus.ramAddr == addrOcrAL);
	assign wrOcrBL = bus.ramwe && (bus.ramAddr == addrOcrBL);
	assign rdTcntL = bus.ramre && (bus.ramAddr == addrTcntL);

	// Any high-byte write goes to the latch first
	assign wrHigh = bus.ramwe && ((bus.ramAddr == addrTcntH) ||
		(bus.ramAddr == addrOcrAH) || (bus.ramAddr == addrOcrBH));

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			tccrA <= '0;
			tccrB <= '0;
			timsk <= '0;
		end else begin
			if (wrTccrA)
				tccrA <= bus.dbusIn & maskTccrA;
			if (wrTccrB)
				tccrB <= bus.dbusIn & maskTccrB;
			if (wrTimsk)
				timsk <= bus.dbusIn & maskTimsk;
		end
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			temp <= '0;
		end else if (rdTcntL) begin
			temp <= count[15:8]; // Freeze high byte for the next read
		end else if (wrHigh) begin
			temp <= bus.dbusIn;
		end
	end

	// Low-byte write commits latch and data in one go
	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ocrA <= '0;
			ocrB <= '0;
		end else begin
			if (wrOcrAL)
				ocrA <= {temp, bus.dbusIn};
			if (wrOcrBL)
				ocrB <= {temp, bus.dbusIn};
		end
	end

	assign load.valid = wrTcntL;
	assign load.value = {temp, bus.dbusIn};

	assign cfg.mode = {1'b0, tccrB[3]}; // WGMn3 not implemented
	assign cfg.comA = tccrA[7:6];
	assign cfg.comB = tccrA[5:4];
	assign cfg.run = |tccrB[2:0];

	always_comb begin
		ramData = '0;
		ramHit = 1'b1;
		case (bus.ramAddr)
			addrTccrA: ramData = tccrA;
			addrTccrB: ramData = tccrB;
			addrTcntL: ramData = count[7:0];
			addrTcntH: ramData = temp;
			addrOcrAL: ramData = ocrA[7:0];
			addrOcrAH: ramData = ocrA[15:8];
			addrOcrBL: ramData = ocrB[7:0];
			addrOcrBH: ramData = ocrB[15:8];
			addrTimsk: ramData = timsk;
			default: ramHit = 1'b0;
		endcase
	end

	// I/O read takes priority, as on the core bus
	always_comb begin
		dbusOut = '0;
		outEn = 1'b0;
		if (bus.iore) begin
			if (bus.ioAddr == addrTifr) begin
				dbusOut = tifr;
				outEn = 1'b1;
			end
		end else if (bus.ramre && ramHit) begin
			dbusOut = ramData;
			outEn = 1'b1;
		end
	end

endmodule

// File: hw/timerPkg.sv
package timerPkg;

	localparam int RamAddrW = 12;
	localparam int IoAddrW = 6;

	// Data-space register map
	localparam logic [RamAddrW-1:0] addrTimsk = 12'h06F;
	localparam logic [RamAddrW-1:0] addrTccrA = 12'h080;
	localparam logic [RamAddrW-1:0] addrTccrB = 12'h081;
	localparam logic [RamAddrW-1:0] addrTcntL = 12'h084;
	localparam logic [RamAddrW-1:0] addrTcntH = 12'h085;
	localparam logic [RamAddrW-1:0] addrOcrAL = 12'h088;
	localparam logic [RamAddrW-1:0] addrOcrAH = 12'h089;
	localparam logic [RamAddrW-1:0] addrOcrBL = 12'h08A;
	localparam logic [RamAddrW-1:0] addrOcrBH = 12'h08B;

	localparam logic [IoAddrW-1:0] addrTifr = 6'h16; // I/O space

	// Interrupt vectors seen on the acknowledge
	localparam logic [IoAddrW-1:0] vecCmpA = 6'h0B;
	localparam logic [IoAddrW-1:0] vecCmpB = 6'h0C;
	localparam logic [IoAddrW-1:0] vecOvf = 6'h0D;

	// WGMn[3:2], only WGM 0 and WGM 4 exist here
	localparam logic [1:0] wgmNormal = 2'b00;
	localparam logic [1:0] wgmCtc = 2'b01;

	localparam logic [1:0] comOff = 2'b00;
	localparam logic [1:0] comToggle = 2'b01;
	localparam logic [1:0] comClear = 2'b10;
	localparam logic [1:0] comSet = 2'b11;

	localparam logic [15:0] cntMax = 16'hFFFF;

	// Bit positions shared by TIFR and TIMSK
	localparam int flagOvf = 0;
	localparam int flagCmpA = 1;
	localparam int flagCmpB = 2;

	// Writable bits of each control register
	localparam logic [7:0] maskTccrA = 8'hF0; // COMnA, COMnB
	localparam logic [7:0] maskTccrB = 8'h0F; // WGMn2, CSn
	localparam logic [7:0] maskTimsk = 8'h07;

	typedef struct packed {
		logic [RamAddrW-1:0] ramAddr;
		logic ramre;
		logic ramwe;
		logic [IoAddrW-1:0] ioAddr;
		logic iore;
		logic iowe;
		logic [7:0] dbusIn;
	} busReq_t;

	typedef struct packed {
		logic [1:0] mode;
		logic [1:0] comA;
		logic [1:0] comB;
		logic run;
	} timerCfg_t;

	typedef struct packed {
		logic tick;
		logic ovf;
		logic matchA;
		logic matchB;
	} cntEvent_t;

	typedef struct packed {
		logic valid;
		logic [15:0] value;
	} cntLoad_t;

	typedef struct packed {
		logic [IoAddrW-1:0] vec;
		logic strobe;
	} irqAck_t;

endpackage
